// ==== src.f ====
design/ex1_pkg.sv
design/fwd_src_if.sv
design/ex1_op_if.sv
design/ex1_capture.sv
design/ex1_lane.sv
design/ex1_out_reg.sv
design/ex1_stage_top.sv
test/ex1_stage_props.sv
test/ex1_stage_tb.sv

// ==== test/ex1_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex1_stage_tb;
    import ex1_pkg::*;

    localparam int N_ALU   = 150;
    localparam int N_FWD   = 150;
    localparam int N_BR    = 150;
    localparam int N_BP    = 200;
    localparam int N_FLUSH = 200;
    localparam int WATCHDOG_CYCLES = (N_ALU + N_FWD + N_BR + N_BP + N_FLUSH) * 20;

    localparam int M_ALU   = 0;
    localparam int M_FWD   = 1;
    localparam int M_BR    = 2;
    localparam int M_BP    = 3;
    localparam int M_FLUSH = 4;
    localparam int M_DRAIN = 5;

    typedef struct packed {
        word_t result;
        word_t redirect;
        logic  pf;
    } lane_res_t;

    typedef struct packed {
        lane_res_t l0;
        lane_res_t l1;
        reg_idx_t  rd0;
        reg_idx_t  rd1;
        int        acc_cycle;
        int        mode;
        logic      stalled;
    } exp_t;

    logic        clk;
    logic        arst_n;
    logic        flush;
    logic        in_valid;
    logic        in_ready;
    logic        out_valid;
    logic        out_ready;
    word_t       pc [2];
    word_t       pred [2];
    uop_t        uop [2];
    word_t       imm [2];
    reg_idx_t    rj [2];
    reg_idx_t    rk [2];
    reg_idx_t    rd [2];
    word_t       rj_data [2];
    word_t       rk_data [2];
    word_t       tid;
    logic [63:0] counter;
    // search order runs from e2 lane 1 down to wb lane 0
    reg_idx_t    fwd_rd [6];
    word_t       fwd_data [6];
    logic        fwd_vld [6];
    word_t       result0;
    word_t       result1;
    reg_idx_t    rd0_out;
    reg_idx_t    rd1_out;
    logic        pf0_out;
    logic        pf1_out;
    word_t       redirect0;
    word_t       redirect1;

    logic [31:0] lfsr_state = 32'd51;
    exp_t        exp_q [$];
    int          cycle;
    int          n_acc;
    int          n_out;
    int          n_dropped;

    ex1_stage_top ex1_stage_top_i (
        .clk              (clk),
        .arst_n_i         (arst_n),
        .flush_i          (flush),
        .in_valid_i       (in_valid),
        .in_ready_o       (in_ready),
        .pc0_i            (pc[0]),
        .pc1_i            (pc[1]),
        .pc0_predict_i    (pred[0]),
        .pc1_predict_i    (pred[1]),
        .uop0_i           (uop[0]),
        .uop1_i           (uop[1]),
        .imm0_i           (imm[0]),
        .imm1_i           (imm[1]),
        .rj0_i            (rj[0]),
        .rk0_i            (rk[0]),
        .rd0_i            (rd[0]),
        .rj1_i            (rj[1]),
        .rk1_i            (rk[1]),
        .rd1_i            (rd[1]),
        .rj0_data_i       (rj_data[0]),
        .rk0_data_i       (rk_data[0]),
        .rj1_data_i       (rj_data[1]),
        .rk1_data_i       (rk_data[1]),
        .tid_i            (tid),
        .stable_counter_i (counter),
        .ex1_ex2_rd1_i    (fwd_rd[0]),
        .ex1_ex2_rd0_i    (fwd_rd[1]),
        .ex1_ex2_data1_i  (fwd_data[0]),
        .ex1_ex2_data0_i  (fwd_data[1]),
        .ex1_ex2_valid1_i (fwd_vld[0]),
        .ex1_ex2_valid0_i (fwd_vld[1]),
        .ex2_ex3_rd1_i    (fwd_rd[2]),
        .ex2_ex3_rd0_i    (fwd_rd[3]),
        .ex2_ex3_data1_i  (fwd_data[2]),
        .ex2_ex3_data0_i  (fwd_data[3]),
        .ex2_ex3_valid1_i (fwd_vld[2]),
        .ex2_ex3_valid0_i (fwd_vld[3]),
        .ex3_wb_rd1_i     (fwd_rd[4]),
        .ex3_wb_rd0_i     (fwd_rd[5]),
        .ex3_wb_data1_i   (fwd_data[4]),
        .ex3_wb_data0_i   (fwd_data[5]),
        .ex3_wb_valid1_i  (fwd_vld[4]),
        .ex3_wb_valid0_i  (fwd_vld[5]),
        .out_valid_o      (out_valid),
        .out_ready_i      (out_ready),
        .result0_o        (result0),
        .result1_o        (result1),
        .rd0_o            (rd0_out),
        .rd1_o            (rd1_out),
        .predict_fail0_o  (pf0_out),
        .predict_fail1_o  (pf1_out),
        .redirect_pc0_o   (redirect0),
        .redirect_pc1_o   (redirect1)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES + 16) @(posedge clk);
        abort_run("watchdog expired, bundles were not accepted or drained in time");
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic word_t rand_word();
        return word_t'(rand_bits(32));
    endfunction

    // values near zero so equal and signed compares hit often
    function automatic word_t small_word();
        logic [2:0] v;
        v = 3'(rand_bits(3));
        return {{29{v[2]}}, v};
    endfunction

    function automatic string phase_name(input int mode);
        case (mode)
            M_ALU:   return "alu_select";
            M_FWD:   return "forward_priority";
            M_BR:    return "branch_resolve";
            M_BP:    return "back_pressure";
            M_FLUSH: return "flush";
            default: return "drain";
        endcase
    endfunction

    function automatic word_t fwd_model(input reg_idx_t idx, input word_t rf);
        if (idx == 5'd0) begin
            return rf;
        end
        for (int s = 0; s < 6; s++) begin
            if (fwd_vld[s] && fwd_rd[s] == idx) begin
                return fwd_data[s];
            end
        end
        return rf;
    endfunction

    function automatic lane_res_t lane_model(input uop_t u, input word_t lpc, input word_t lpred,
                                             input word_t rjv, input word_t rkv,
                                             input word_t limm, input word_t ltid,
                                             input logic [63:0] cnt);
        lane_res_t r;
        word_t     a;
        word_t     b;
        logic      tk;
        case (u.src1)
            SRC1_RJ:   a = rjv;
            SRC1_PC:   a = lpc;
            SRC1_ZERO: a = 32'd0;
            default:   a = ltid;
        endcase
        case (u.src2)
            SRC2_RK:     b = rkv;
            SRC2_IMM:    b = limm;
            SRC2_CNT_LO: b = cnt[31:0];
            default:     b = cnt[63:32];
        endcase
        r.redirect = lpc + 32'd4;
        if (u.cls == CLS_BR) begin
            case (u.func.br)
                BR_EQ:   tk = (rjv == rkv);
                BR_NE:   tk = (rjv != rkv);
                BR_LT:   tk = ($signed(rjv) < $signed(rkv));
                BR_GE:   tk = !($signed(rjv) < $signed(rkv));
                BR_LTU:  tk = (rjv < rkv);
                BR_GEU:  tk = !(rjv < rkv);
                default: tk = 1'b1;
            endcase
            // link address
            r.result = lpc + 32'd4;
            if (tk) begin
                r.redirect = lpc + limm;
            end
        end else begin
            case (u.func.alu)
                ALU_ADD:  r.result = a + b;
                ALU_SUB:  r.result = a - b;
                ALU_SLT:  r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                ALU_SLTU: r.result = (a < b) ? 32'd1 : 32'd0;
                ALU_AND:  r.result = a & b;
                ALU_OR:   r.result = a | b;
                ALU_NOR:  r.result = ~(a | b);
                ALU_XOR:  r.result = a ^ b;
                ALU_SLL:  r.result = a << b[4:0];
                ALU_SRL:  r.result = a >> b[4:0];
                ALU_SRA:  r.result = $signed(a) >>> b[4:0];
                default:  r.result = b;
            endcase
        end
        r.pf = (r.redirect != lpred);
        return r;
    endfunction

    task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, exp_v, act_v));
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp_v, input reg_idx_t act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp_v, act_v));
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("ERR %s expected %b actual %b", name, exp_v, act_v));
        end
    endtask

    task automatic compare_bundle(input exp_t e);
        string t;
        t = phase_name(e.mode);
        if (!e.stalled && (cycle - e.acc_cycle) != 2) begin
            abort_run($sformatf("%s: bundle took %0d cycles with no stall, 2 were due",
                                t, cycle - e.acc_cycle));
        end else begin
            check_word({t, " result0"}, e.l0.result, result0);
            check_word({t, " result1"}, e.l1.result, result1);
            check_idx({t, " rd0"}, e.rd0, rd0_out);
            check_idx({t, " rd1"}, e.rd1, rd1_out);
            check_bit({t, " predict_fail0"}, e.l0.pf, pf0_out);
            check_bit({t, " predict_fail1"}, e.l1.pf, pf1_out);
            check_word({t, " redirect_pc0"}, e.l0.redirect, redirect0);
            check_word({t, " redirect_pc1"}, e.l1.redirect, redirect1);
        end
    endtask

    task automatic drive_next(input int mode, input logic took);
        uop_t       u;
        word_t      p;
        word_t      im;
        logic [1:0] pick;
        // a refused bundle is held as it is
        if (took || !in_valid) begin
            if (mode == M_DRAIN) begin
                in_valid <= 1'b0;
            end else begin
                in_valid <= (mode >= M_BP) ? (rand_bits(2) != 0) : 1'b1;
            end
            for (int l = 0; l < 2; l++) begin
                u.cls  = (mode == M_BR) ? CLS_BR :
                         (mode >= M_BP) ? uop_cls_e'(1'(rand_bits(1))) : CLS_ALU;
                u.src1 = src1_sel_e'(2'(rand_bits(2)));
                u.src2 = src2_sel_e'(2'(rand_bits(2)));
                if (u.cls == CLS_BR) begin
                    u.func.br = br_cond_e'(4'(rand_bits(4) % 7));
                end else if (mode == M_FWD) begin
                    u.src1     = SRC1_RJ;
                    u.src2     = SRC2_RK;
                    u.func.alu = rand_bits(1) ? ALU_XOR : ALU_ADD;
                end else begin
                    u.func.alu = alu_op_e'(4'(rand_bits(4) % 12));
                end
                p    = rand_word();
                p    = {p[31:2], 2'b00};
                im   = rand_word();
                pick = 2'(rand_bits(2));
                uop[l]  <= u;
                pc[l]   <= p;
                imm[l]  <= im;
                pred[l] <= (pick == 2'd2) ? p + im : (pick == 2'd3) ? rand_word() : p + 32'd4;
                rj[l]   <= reg_idx_t'(rand_bits(2));
                rk[l]   <= reg_idx_t'(rand_bits(2));
                rd[l]   <= reg_idx_t'(rand_bits(5));
                rj_data[l] <= (mode == M_BR) ? small_word() : rand_word();
                rk_data[l] <= (mode == M_BR) ? small_word() : rand_word();
            end
            tid     <= rand_word();
            counter <= rand_bits(64);
        end
        for (int s = 0; s < 6; s++) begin
            fwd_rd[s]   <= reg_idx_t'(rand_bits(2));
            fwd_data[s] <= (mode == M_BR) ? small_word() : rand_word();
            fwd_vld[s]  <= (mode == M_FWD) ? (rand_bits(2) != 0) : (rand_bits(2) == 0);
        end
        out_ready <= (mode == M_BP || mode == M_FLUSH) ? (rand_bits(3) > 2) : 1'b1;
        flush     <= (mode == M_FLUSH) && (rand_bits(3) == 0);
    endtask

    task automatic cycle_step(input int mode);
        exp_t e;
        logic took;
        @(posedge clk);
        cycle++;
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("output transfer seen with no bundle in flight");
            end else begin
                e = exp_q.pop_front();
                compare_bundle(e);
                n_out++;
            end
        end
        took = in_valid && in_ready;
        if (flush) begin
            n_dropped += exp_q.size();
            exp_q.delete();
        end else if (took) begin
            e.l0 = lane_model(uop[0], pc[0], pred[0], fwd_model(rj[0], rj_data[0]),
                              fwd_model(rk[0], rk_data[0]), imm[0], tid, counter);
            e.l1 = lane_model(uop[1], pc[1], pred[1], fwd_model(rj[1], rj_data[1]),
                              fwd_model(rk[1], rk_data[1]), imm[1], tid, counter);
            e.rd0       = rd[0];
            e.rd1       = rd[1];
            e.acc_cycle = cycle;
            e.mode      = mode;
            e.stalled   = 1'b0;
            exp_q.push_back(e);
        end
        // latency is only fixed for bundles that never saw a stall
        if (!out_ready) begin
            foreach (exp_q[i]) begin
                exp_q[i].stalled = 1'b1;
            end
        end
        if (took) begin
            n_acc++;
        end
        drive_next(mode, took);
    endtask

    task automatic run_phase(input int mode, input int n_ops);
        int start;
        start = n_acc;
        while (n_acc - start < n_ops) begin
            cycle_step(mode);
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        tid       = '0;
        counter   = '0;
        for (int l = 0; l < 2; l++) begin
            pc[l]      = '0;
            pred[l]    = '0;
            uop[l]     = '0;
            imm[l]     = '0;
            rj[l]      = '0;
            rk[l]      = '0;
            rd[l]      = '0;
            rj_data[l] = '0;
            rk_data[l] = '0;
        end
        for (int s = 0; s < 6; s++) begin
            fwd_rd[s]   = '0;
            fwd_data[s] = '0;
            fwd_vld[s]  = 1'b0;
        end
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        run_phase(M_ALU, N_ALU);
        run_phase(M_FWD, N_FWD);
        run_phase(M_BR, N_BR);
        run_phase(M_BP, N_BP);
        run_phase(M_FLUSH, N_FLUSH);
        while (exp_q.size() != 0 || in_valid) begin
            cycle_step(M_DRAIN);
        end
        // nothing extra may come out
        repeat (4) cycle_step(M_DRAIN);
        if (exp_q.size() == 0 && n_dropped != 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run($sformatf("no bundle in flight was flushed, %0d out, %0d still queued",
                                n_out, exp_q.size()));
        end
    end

endmodule

`default_nettype wire

// ==== test/ex1_stage_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex1_stage_props (
    input logic         clk,
    input logic         arst_n_i,
    input logic         flush_i,
    input logic         out_ready_i,
    input logic         out_valid_i,
    input logic         in_ready_i,
    input logic [139:0] out_bus_i
);

    // output register comes out of reset empty
    assert property (@(posedge clk) !arst_n_i |=> !out_valid_i)
        else $error("out_valid_o high right after reset");

    // stalled bundle holds every output field
    assert property (@(posedge clk) disable iff (!arst_n_i)
        (out_valid_i && !out_ready_i && !flush_i) |=> (out_valid_i && $stable(out_bus_i)))
        else $error("outputs changed while stalled");

    assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !out_valid_i)
        else $error("out_valid_o high in the cycle after a flush");

    // a draining output register always frees the capture slot
    assert property (@(posedge clk) disable iff (!arst_n_i)
        out_ready_i |-> in_ready_i)
        else $error("in_ready_o low although out_ready_i is high");

endmodule

bind ex1_stage_top ex1_stage_props ex1_stage_props_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .out_ready_i (out_ready_i),
    .out_valid_i (out_valid_o),
    .in_ready_i  (in_ready_o),
    .out_bus_i   ({result0_o, result1_o, rd0_o, rd1_o, predict_fail0_o, predict_fail1_o,
                   redirect_pc0_o, redirect_pc1_o})
);

`default_nettype wire

// ==== design/ex1_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex1_stage_top (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              flush_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  ex1_pkg::word_t    pc0_i,
    input  ex1_pkg::word_t    pc1_i,
    input  ex1_pkg::word_t    pc0_predict_i,
    input  ex1_pkg::word_t    pc1_predict_i,
    input  ex1_pkg::uop_t     uop0_i,
    input  ex1_pkg::uop_t     uop1_i,
    input  ex1_pkg::word_t    imm0_i,
    input  ex1_pkg::word_t    imm1_i,
    input  ex1_pkg::reg_idx_t rj0_i,
    input  ex1_pkg::reg_idx_t rk0_i,
    input  ex1_pkg::reg_idx_t rd0_i,
    input  ex1_pkg::reg_idx_t rj1_i,
    input  ex1_pkg::reg_idx_t rk1_i,
    input  ex1_pkg::reg_idx_t rd1_i,
    input  ex1_pkg::word_t    rj0_data_i,
    input  ex1_pkg::word_t    rk0_data_i,
    input  ex1_pkg::word_t    rj1_data_i,
    input  ex1_pkg::word_t    rk1_data_i,
    input  ex1_pkg::word_t    tid_i,
    input  logic [63:0]       stable_counter_i,
    input  ex1_pkg::reg_idx_t ex1_ex2_rd0_i,
    input  ex1_pkg::reg_idx_t ex1_ex2_rd1_i,
    input  ex1_pkg::word_t    ex1_ex2_data0_i,
    input  ex1_pkg::word_t    ex1_ex2_data1_i,
    input  logic              ex1_ex2_valid0_i,
    input  logic              ex1_ex2_valid1_i,
    input  ex1_pkg::reg_idx_t ex2_ex3_rd0_i,
    input  ex1_pkg::reg_idx_t ex2_ex3_rd1_i,
    input  ex1_pkg::word_t    ex2_ex3_data0_i,
    input  ex1_pkg::word_t    ex2_ex3_data1_i,
    input  logic              ex2_ex3_valid0_i,
    input  logic              ex2_ex3_valid1_i,
    input  ex1_pkg::reg_idx_t ex3_wb_rd0_i,
    input  ex1_pkg::reg_idx_t ex3_wb_rd1_i,
    input  ex1_pkg::word_t    ex3_wb_data0_i,
    input  ex1_pkg::word_t    ex3_wb_data1_i,
    input  logic              ex3_wb_valid0_i,
    input  logic              ex3_wb_valid1_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output ex1_pkg::word_t    result0_o,
    output ex1_pkg::word_t    result1_o,
    output ex1_pkg::reg_idx_t rd0_o,
    output ex1_pkg::reg_idx_t rd1_o,
    output logic              predict_fail0_o,
    output logic              predict_fail1_o,
    output ex1_pkg::word_t    redirect_pc0_o,
    output ex1_pkg::word_t    redirect_pc1_o
);
    import ex1_pkg::*;

    logic     advance;
    word_t    lane0_result;
    word_t    lane1_result;
    reg_idx_t lane0_rd;
    reg_idx_t lane1_rd;
    logic     lane0_pf;
    logic     lane1_pf;
    word_t    lane0_redirect;
    word_t    lane1_redirect;

    fwd_src_if fwd_e2();
    fwd_src_if fwd_e3();
    fwd_src_if fwd_wb();
    ex1_op_if  op0();
    ex1_op_if  op1();

    assign fwd_e2.rd0    = ex1_ex2_rd0_i;
    assign fwd_e2.rd1    = ex1_ex2_rd1_i;
    assign fwd_e2.data0  = ex1_ex2_data0_i;
    assign fwd_e2.data1  = ex1_ex2_data1_i;
    assign fwd_e2.valid0 = ex1_ex2_valid0_i;
    assign fwd_e2.valid1 = ex1_ex2_valid1_i;
    assign fwd_e3.rd0    = ex2_ex3_rd0_i;
    assign fwd_e3.rd1    = ex2_ex3_rd1_i;
    assign fwd_e3.data0  = ex2_ex3_data0_i;
    assign fwd_e3.data1  = ex2_ex3_data1_i;
    assign fwd_e3.valid0 = ex2_ex3_valid0_i;
    assign fwd_e3.valid1 = ex2_ex3_valid1_i;
    assign fwd_wb.rd0    = ex3_wb_rd0_i;
    assign fwd_wb.rd1    = ex3_wb_rd1_i;
    assign fwd_wb.data0  = ex3_wb_data0_i;
    assign fwd_wb.data1  = ex3_wb_data1_i;
    assign fwd_wb.valid0 = ex3_wb_valid0_i;
    assign fwd_wb.valid1 = ex3_wb_valid1_i;

    // port names match the top level one to one
    ex1_capture ex1_capture_i (
        .advance_i (advance),
        .*
    );

    ex1_lane ex1_lane0_i (
        .op             (op0),
        .result_o       (lane0_result),
        .rd_o           (lane0_rd),
        .predict_fail_o (lane0_pf),
        .redirect_pc_o  (lane0_redirect)
    );

    ex1_lane ex1_lane1_i (
        .op             (op1),
        .result_o       (lane1_result),
        .rd_o           (lane1_rd),
        .predict_fail_o (lane1_pf),
        .redirect_pc_o  (lane1_redirect)
    );

    ex1_out_reg ex1_out_reg_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .in_valid_i      (op0.valid),
        .advance_o       (advance),
        .out_ready_i     (out_ready_i),
        .result0_i       (lane0_result),
        .result1_i       (lane1_result),
        .rd0_i           (lane0_rd),
        .rd1_i           (lane1_rd),
        .predict_fail0_i (lane0_pf),
        .predict_fail1_i (lane1_pf),
        .redirect_pc0_i  (lane0_redirect),
        .redirect_pc1_i  (lane1_redirect),
        .out_valid_o     (out_valid_o),
        .result0_o       (result0_o),
        .result1_o       (result1_o),
        .rd0_o           (rd0_o),
        .rd1_o           (rd1_o),
        .predict_fail0_o (predict_fail0_o),
        .predict_fail1_o (predict_fail1_o),
        .redirect_pc0_o  (redirect_pc0_o),
        .redirect_pc1_o  (redirect_pc1_o)
    );

endmodule

`default_nettype wire

// ==== design/ex1_out_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex1_out_reg (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              flush_i,
    input  logic              in_valid_i,
    output logic              advance_o,
    input  logic              out_ready_i,
    input  ex1_pkg::word_t    result0_i,
    input  ex1_pkg::word_t    result1_i,
    input  ex1_pkg::reg_idx_t rd0_i,
    input  ex1_pkg::reg_idx_t rd1_i,
    input  logic              predict_fail0_i,
    input  logic              predict_fail1_i,
    input  ex1_pkg::word_t    redirect_pc0_i,
    input  ex1_pkg::word_t    redirect_pc1_i,
    output logic              out_valid_o,
    output ex1_pkg::word_t    result0_o,
    output ex1_pkg::word_t    result1_o,
    output ex1_pkg::reg_idx_t rd0_o,
    output ex1_pkg::reg_idx_t rd1_o,
    output logic              predict_fail0_o,
    output logic              predict_fail1_o,
    output ex1_pkg::word_t    redirect_pc0_o,
    output ex1_pkg::word_t    redirect_pc1_o
);
    logic out_valid_q;
    logic pf0_q;
    logic pf1_q;

    assign advance_o = !out_valid_q || out_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            out_valid_q <= 1'b0;
        end else if (advance_o) begin
            out_valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o && in_valid_i) begin
            result0_o      <= result0_i;
            result1_o      <= result1_i;
            rd0_o          <= rd0_i;
            rd1_o          <= rd1_i;
            pf0_q          <= predict_fail0_i;
            pf1_q          <= predict_fail1_i;
            redirect_pc0_o <= redirect_pc0_i;
            redirect_pc1_o <= redirect_pc1_i;
        end
    end

    assign out_valid_o     = out_valid_q;
    assign predict_fail0_o = out_valid_q && pf0_q;
    assign predict_fail1_o = out_valid_q && pf1_q;

endmodule

`default_nettype wire

// ==== design/ex1_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex1_lane (
    ex1_op_if.dst             op,
    output ex1_pkg::word_t    result_o,
    output ex1_pkg::reg_idx_t rd_o,
    output logic              predict_fail_o,
    output ex1_pkg::word_t    redirect_pc_o
);
    import ex1_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      alu_y;
    word_t      pc_seq;
    word_t      br_target;
    logic [4:0] shamt;
    logic       is_br;
    logic       taken;

    always_comb begin
        case (op.uop.src1)
            SRC1_RJ:   op_a = op.rj_data;
            SRC1_PC:   op_a = op.pc;
            SRC1_ZERO: op_a = '0;
            default:   op_a = op.tid;
        endcase
    end

    always_comb begin
        case (op.uop.src2)
            SRC2_RK:     op_b = op.rk_data;
            SRC2_IMM:    op_b = op.imm;
            SRC2_CNT_LO: op_b = op.counter[31:0];
            default:     op_b = op.counter[63:32];
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (op.uop.func.alu)
            ALU_ADD:   alu_y = op_a + op_b;
            ALU_SUB:   alu_y = op_a - op_b;
            ALU_SLT:   alu_y = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:  alu_y = word_t'(op_a < op_b);
            ALU_AND:   alu_y = op_a & op_b;
            ALU_OR:    alu_y = op_a | op_b;
            ALU_NOR:   alu_y = ~(op_a | op_b);
            ALU_XOR:   alu_y = op_a ^ op_b;
            ALU_SLL:   alu_y = op_a << shamt;
            ALU_SRL:   alu_y = op_a >> shamt;
            ALU_SRA:   alu_y = $signed(op_a) >>> shamt;
            ALU_PASSB: alu_y = op_b;
            default:   alu_y = '0;
        endcase
    end

    // compare always on the resolved register data
    always_comb begin
        case (op.uop.func.br)
            BR_EQ:     taken = op.rj_data == op.rk_data;
            BR_NE:     taken = op.rj_data != op.rk_data;
            BR_LT:     taken = $signed(op.rj_data) < $signed(op.rk_data);
            BR_GE:     taken = $signed(op.rj_data) >= $signed(op.rk_data);
            BR_LTU:    taken = op.rj_data < op.rk_data;
            BR_GEU:    taken = op.rj_data >= op.rk_data;
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign is_br     = op.uop.cls == CLS_BR;
    assign pc_seq    = op.pc + 32'd4;
    assign br_target = op.pc + op.imm;

    // branches write the link address
    assign result_o      = is_br ? pc_seq : alu_y;
    assign rd_o          = op.rd;
    assign redirect_pc_o = (is_br && taken) ? br_target : pc_seq;
    // an empty lane never flags a mispredict
    assign predict_fail_o = op.valid && (redirect_pc_o != op.pc_predict);

endmodule

`default_nettype wire

// ==== design/ex1_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex1_capture (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              flush_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic              advance_i,
    input  ex1_pkg::word_t    pc0_i,
    input  ex1_pkg::word_t    pc1_i,
    input  ex1_pkg::word_t    pc0_predict_i,
    input  ex1_pkg::word_t    pc1_predict_i,
    input  ex1_pkg::uop_t     uop0_i,
    input  ex1_pkg::uop_t     uop1_i,
    input  ex1_pkg::word_t    imm0_i,
    input  ex1_pkg::word_t    imm1_i,
    input  ex1_pkg::reg_idx_t rj0_i,
    input  ex1_pkg::reg_idx_t rk0_i,
    input  ex1_pkg::reg_idx_t rd0_i,
    input  ex1_pkg::reg_idx_t rj1_i,
    input  ex1_pkg::reg_idx_t rk1_i,
    input  ex1_pkg::reg_idx_t rd1_i,
    input  ex1_pkg::word_t    rj0_data_i,
    input  ex1_pkg::word_t    rk0_data_i,
    input  ex1_pkg::word_t    rj1_data_i,
    input  ex1_pkg::word_t    rk1_data_i,
    input  ex1_pkg::word_t    tid_i,
    input  logic [63:0]       stable_counter_i,
    fwd_src_if.consumer       fwd_e2,
    fwd_src_if.consumer       fwd_e3,
    fwd_src_if.consumer       fwd_wb,
    ex1_op_if.src             op0,
    ex1_op_if.src             op1
);
    import ex1_pkg::*;

    logic           cap_valid_q;
    logic           accept;
    reg_idx_t [5:0] fwd_rd;
    word_t [5:0]    fwd_data;
    logic [5:0]     fwd_vld;
    word_t          rj0_fwd;
    word_t          rk0_fwd;
    word_t          rj1_fwd;
    word_t          rk1_fwd;

    // slot 0 is the youngest producer: e2 lane 1, then e2 lane 0, e3 ..., wb lane 0
    function automatic word_t resolve(input reg_idx_t idx, input word_t rf_data,
                                      input reg_idx_t [5:0] rd_v, input word_t [5:0] data_v,
                                      input logic [5:0] vld_v);
        word_t res;
        res = rf_data;
        // walk from oldest so the youngest hit is left standing
        for (int i = 5; i >= 0; i--) begin
            if (idx != '0 && vld_v[i] && rd_v[i] == idx) begin
                res = data_v[i];
            end
        end
        return res;
    endfunction

    assign fwd_rd   = {fwd_wb.rd0, fwd_wb.rd1, fwd_e3.rd0, fwd_e3.rd1, fwd_e2.rd0, fwd_e2.rd1};
    assign fwd_data = {fwd_wb.data0, fwd_wb.data1, fwd_e3.data0, fwd_e3.data1,
                       fwd_e2.data0, fwd_e2.data1};
    assign fwd_vld  = {fwd_wb.valid0, fwd_wb.valid1, fwd_e3.valid0, fwd_e3.valid1,
                       fwd_e2.valid0, fwd_e2.valid1};

    assign rj0_fwd = resolve(rj0_i, rj0_data_i, fwd_rd, fwd_data, fwd_vld);
    assign rk0_fwd = resolve(rk0_i, rk0_data_i, fwd_rd, fwd_data, fwd_vld);
    assign rj1_fwd = resolve(rj1_i, rj1_data_i, fwd_rd, fwd_data, fwd_vld);
    assign rk1_fwd = resolve(rk1_i, rk1_data_i, fwd_rd, fwd_data, fwd_vld);

    // free slot, or the held bundle leaves this cycle
    assign in_ready_o = !cap_valid_q || advance_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cap_valid_q <= 1'b0;
        end else if (flush_i) begin
            cap_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            cap_valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op0.uop        <= uop0_i;
            op0.pc         <= pc0_i;
            op0.pc_predict <= pc0_predict_i;
            op0.rj_data    <= rj0_fwd;
            op0.rk_data    <= rk0_fwd;
            op0.imm        <= imm0_i;
            op0.rd         <= rd0_i;
            op0.tid        <= tid_i;
            op0.counter    <= stable_counter_i;
            op1.uop        <= uop1_i;
            op1.pc         <= pc1_i;
            op1.pc_predict <= pc1_predict_i;
            op1.rj_data    <= rj1_fwd;
            op1.rk_data    <= rk1_fwd;
            op1.imm        <= imm1_i;
            op1.rd         <= rd1_i;
            op1.tid        <= tid_i;
            op1.counter    <= stable_counter_i;
        end
    end

    assign op0.valid = cap_valid_q;
    assign op1.valid = cap_valid_q;

endmodule

`default_nettype wire

// ==== design/ex1_op_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ex1_op_if;
    import ex1_pkg::*;

    logic        valid;
    uop_t        uop;
    word_t       pc;
    word_t       pc_predict;
    word_t       rj_data;
    word_t       rk_data;
    word_t       imm;
    reg_idx_t    rd;
    word_t       tid;
    logic [63:0] counter;

    modport src (
        output valid, uop, pc, pc_predict, rj_data, rk_data, imm, rd, tid, counter
    );

    modport dst (
        input valid, uop, pc, pc_predict, rj_data, rk_data, imm, rd, tid, counter
    );

endinterface

`default_nettype wire

// ==== design/fwd_src_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fwd_src_if;
    import ex1_pkg::*;

    reg_idx_t rd0;
    reg_idx_t rd1;
    word_t    data0;
    word_t    data1;
    logic     valid0;
    logic     valid1;

    modport producer (
        output rd0, rd1, data0, data1, valid0, valid1
    );

    modport consumer (
        input rd0, rd1, data0, data1, valid0, valid1
    );

endinterface

`default_nettype wire

// ==== design/ex1_pkg.sv ====
`default_nettype none

package ex1_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic {
        CLS_ALU = 1'b0,
        CLS_BR  = 1'b1
    } uop_cls_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLT   = 4'd2,
        ALU_SLTU  = 4'd3,
        ALU_AND   = 4'd4,
        ALU_OR    = 4'd5,
        ALU_NOR   = 4'd6,
        ALU_XOR   = 4'd7,
        ALU_SLL   = 4'd8,
        ALU_SRL   = 4'd9,
        ALU_SRA   = 4'd10,
        ALU_PASSB = 4'd11
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_EQ     = 4'd0,
        BR_NE     = 4'd1,
        BR_LT     = 4'd2,
        BR_GE     = 4'd3,
        BR_LTU    = 4'd4,
        BR_GEU    = 4'd5,
        BR_ALWAYS = 4'd6
    } br_cond_e;

    // same four bits, meaning depends on the class
    typedef union packed {
        alu_op_e  alu;
        br_cond_e br;
    } uop_func_u;

    typedef enum logic [1:0] {
        SRC1_RJ   = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2,
        SRC1_TID  = 2'd3
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RK     = 2'd0,
        SRC2_IMM    = 2'd1,
        SRC2_CNT_LO = 2'd2,
        SRC2_CNT_HI = 2'd3
    } src2_sel_e;

    typedef struct packed {
        uop_cls_e  cls;
        src1_sel_e src1;
        src2_sel_e src2;
        uop_func_u func;
    } uop_t;

endpackage

`default_nettype wire
